//--- verilog/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// word formats, signed Q8.8
`define DATA_WIDTH              16
`define FRAC_BITS               8
`define ACC_WIDTH               40
`define KERNEL                  3
`define KIDX_WIDTH              2     // holds 0 .. KERNEL-1
`define DIM_WIDTH               6     // sizes, depths and loop counts
`define LAYER_CODE_WIDTH        4

// external RAM address widths
`define LAYER_ADDR_WIDTH        10
`define WEIGHT_ADDR_WIDTH       6
`define BIAS_ADDR_WIDTH         2

// ping-pong layer regions
`define LAYER_RAM_START_INDEX_0 0
`define LAYER_RAM_START_INDEX_1 256

`define CONV1_FM                6
`define CONV1_FM_DEPTH          2
`define CONV1_KERNELS           2
`define CONV1_STRIDE            1
`define CONV1_WEIGHT_BASE       0
`define CONV1_BIAS_BASE         0

`define CONV2_FM                4
`define CONV2_FM_DEPTH          2
`define CONV2_KERNELS           2
`define CONV2_STRIDE            1
`define CONV2_WEIGHT_BASE       12    // after the 2*2*3 rows of conv1
`define CONV2_BIAS_BASE         2

// layer codes, pool and fc codes are left out
`define LAYER_IDLE              0
`define LAYER_CONV1             1
`define LAYER_CONV2             3

`endif

//--- verilog/convPkg.sv
`default_nettype none

`include "conv_macros.svh"

package convPkg;

    // per-layer setup, loaded on a layer change
    typedef struct packed {
        logic [`LAYER_ADDR_WIDTH-1:0]  inBase;
        logic [`LAYER_ADDR_WIDTH-1:0]  outBase;
        logic [`DIM_WIDTH-1:0]         fmSize;
        logic [`DIM_WIDTH-1:0]         depth;
        logic [`DIM_WIDTH-1:0]         kernels;
        logic [`DIM_WIDTH-1:0]         stride;
        logic [`DIM_WIDTH-1:0]         outSize;    // output edge
        logic [`WEIGHT_ADDR_WIDTH-1:0] weightBase;
        logic [`BIAS_ADDR_WIDTH-1:0]   biasBase;
    } layerCfg_t;

    // travels with each issued kernel element
    typedef struct packed {
        logic valid;
        logic first;    // first element of a pixel
        logic last;     // last element of a pixel
    } macTag_t;

    typedef struct packed {
        logic                          valid;
        logic signed [`ACC_WIDTH-1:0]  sum;
        logic signed [`DATA_WIDTH-1:0] bias;
    } macResult_t;

    // layer RAM write port
    typedef struct packed {
        logic                          en;
        logic [`LAYER_ADDR_WIDTH-1:0]  addr;
        logic [`DATA_WIDTH-1:0]        data;
    } layerWrite_t;

endpackage

`default_nettype wire

//--- verilog/layerDecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module layerDecode (
    input  wire                          clk,
    input  wire                          convRst,
    input  wire [`LAYER_CODE_WIDTH-1:0]  runLayer,
    output convPkg::layerCfg_t           cfg,
    output logic                         start
);

    logic [`LAYER_CODE_WIDTH-1:0] runLayerQ;
    logic [`LAYER_CODE_WIDTH-1:0] currentLayer;
    convPkg::layerCfg_t           nextCfg;
    logic                         supported;

    function automatic convPkg::layerCfg_t makeCfg(
        input int inBase,
        input int outBase,
        input int fmSize,
        input int depth,
        input int kernels,
        input int stride,
        input int weightBase,
        input int biasBase
    );
        convPkg::layerCfg_t c;
        c.inBase     = `LAYER_ADDR_WIDTH'(inBase);
        c.outBase    = `LAYER_ADDR_WIDTH'(outBase);
        c.fmSize     = `DIM_WIDTH'(fmSize);
        c.depth      = `DIM_WIDTH'(depth);
        c.kernels    = `DIM_WIDTH'(kernels);
        c.stride     = `DIM_WIDTH'(stride);
        c.outSize    = `DIM_WIDTH'((fmSize - `KERNEL) / stride + 1);  // valid windows only
        c.weightBase = `WEIGHT_ADDR_WIDTH'(weightBase);
        c.biasBase   = `BIAS_ADDR_WIDTH'(biasBase);
        return c;
    endfunction

    // conv1 reads region 0, conv2 reads region 1
    always_comb begin
        nextCfg   = '0;
        supported = 1'b0;
        case (runLayerQ)
            `LAYER_CODE_WIDTH'(`LAYER_CONV1): begin
                nextCfg = makeCfg(`LAYER_RAM_START_INDEX_0, `LAYER_RAM_START_INDEX_1,
                                  `CONV1_FM, `CONV1_FM_DEPTH, `CONV1_KERNELS, `CONV1_STRIDE,
                                  `CONV1_WEIGHT_BASE, `CONV1_BIAS_BASE);
                supported = 1'b1;
            end
            `LAYER_CODE_WIDTH'(`LAYER_CONV2): begin
                nextCfg = makeCfg(`LAYER_RAM_START_INDEX_1, `LAYER_RAM_START_INDEX_0,
                                  `CONV2_FM, `CONV2_FM_DEPTH, `CONV2_KERNELS, `CONV2_STRIDE,
                                  `CONV2_WEIGHT_BASE, `CONV2_BIAS_BASE);
                supported = 1'b1;
            end
            default: supported = 1'b0;  // idle, pool, fc
        endcase
    end

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            runLayerQ    <= `LAYER_CODE_WIDTH'(`LAYER_IDLE);
            currentLayer <= `LAYER_CODE_WIDTH'(`LAYER_IDLE);
            cfg          <= '0;
            start        <= 1'b0;
        end else begin
            runLayerQ <= runLayer;
            start     <= 1'b0;
            if (runLayerQ != currentLayer) begin
                currentLayer <= runLayerQ;
                if (supported) begin
                    cfg   <= nextCfg;
                    start <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/convWindowCtrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module convWindowCtrl (
    input  wire                            clk,
    input  wire                            convRst,
    input  wire convPkg::layerCfg_t        cfg,
    input  wire                            start,
    output logic [`LAYER_ADDR_WIDTH-1:0]   layerReadAddr,
    output logic [`WEIGHT_ADDR_WIDTH-1:0]  weightReadAddr,
    output logic [`BIAS_ADDR_WIDTH-1:0]    biasReadAddr,
    output convPkg::macTag_t               issueTag,
    output logic [`KIDX_WIDTH-1:0]         weightCol,
    output logic                           issueDone
);

    logic                         active;
    logic                         issuing;

    // loop position, outermost first
    logic [`DIM_WIDTH-1:0]        kCnt, oyCnt, oxCnt, dCnt;
    logic [`KIDX_WIDTH-1:0]       kyCnt, kxCnt;
    logic [`DIM_WIDTH-1:0]        curK, curOy, curOx, curD;
    logic [`KIDX_WIDTH-1:0]       curKy, curKx;
    logic [`DIM_WIDTH-1:0]        nK, nOy, nOx, nD;
    logic [`KIDX_WIDTH-1:0]       nKy, nKx;

    logic                         kLast, oyLast, oxLast, dLast, kyLast, kxLast;
    logic                         wrapKy, wrapD, wrapOx, wrapOy, allDone;
    logic                         firstElem;

    logic [`LAYER_ADDR_WIDTH-1:0] inRow, inCol, planeOff;

    assign issuing = start | active;

    // start issues element zero in the same cycle
    assign curK  = start ? '0 : kCnt;
    assign curOy = start ? '0 : oyCnt;
    assign curOx = start ? '0 : oxCnt;
    assign curD  = start ? '0 : dCnt;
    assign curKy = start ? '0 : kyCnt;
    assign curKx = start ? '0 : kxCnt;

    assign kxLast = curKx == `KIDX_WIDTH'(`KERNEL - 1);
    assign kyLast = curKy == `KIDX_WIDTH'(`KERNEL - 1);
    assign dLast  = curD  == cfg.depth - 1'b1;
    assign oxLast = curOx == cfg.outSize - 1'b1;
    assign oyLast = curOy == cfg.outSize - 1'b1;
    assign kLast  = curK  == cfg.kernels - 1'b1;

    // carry chain
    assign wrapKy  = kxLast & kyLast;
    assign wrapD   = wrapKy & dLast;        // last element of the pixel
    assign wrapOx  = wrapD & oxLast;
    assign wrapOy  = wrapOx & oyLast;
    assign allDone = wrapOy & kLast;

    assign nKx = kxLast  ? '0 : curKx + 1'b1;
    assign nKy = !kxLast ? curKy : (kyLast ? '0 : curKy + 1'b1);
    assign nD  = !wrapKy ? curD  : (dLast  ? '0 : curD + 1'b1);
    assign nOx = !wrapD  ? curOx : (oxLast ? '0 : curOx + 1'b1);
    assign nOy = !wrapOx ? curOy : (oyLast ? '0 : curOy + 1'b1);
    assign nK  = !wrapOy ? curK  : (kLast  ? '0 : curK + 1'b1);

    assign firstElem = (curD == '0) && (curKy == '0) && (curKx == '0);

    //////////////////////////////////////////////////
    // read addresses
    //////////////////////////////////////////////////

    assign inRow    = `LAYER_ADDR_WIDTH'(curOy) * `LAYER_ADDR_WIDTH'(cfg.stride)
                    + `LAYER_ADDR_WIDTH'(curKy);
    assign inCol    = `LAYER_ADDR_WIDTH'(curOx) * `LAYER_ADDR_WIDTH'(cfg.stride)
                    + `LAYER_ADDR_WIDTH'(curKx);
    assign planeOff = `LAYER_ADDR_WIDTH'(curD) * `LAYER_ADDR_WIDTH'(cfg.fmSize)
                    * `LAYER_ADDR_WIDTH'(cfg.fmSize);

    always_ff @(posedge clk) begin
        layerReadAddr  <= cfg.inBase + planeOff + inRow * `LAYER_ADDR_WIDTH'(cfg.fmSize) + inCol;
        // one weight word per kernel row
        weightReadAddr <= cfg.weightBase
                        + `WEIGHT_ADDR_WIDTH'(curK) * `WEIGHT_ADDR_WIDTH'(cfg.depth)
                          * `WEIGHT_ADDR_WIDTH'(`KERNEL)
                        + `WEIGHT_ADDR_WIDTH'(curD) * `WEIGHT_ADDR_WIDTH'(`KERNEL)
                        + `WEIGHT_ADDR_WIDTH'(curKy);
        biasReadAddr   <= cfg.biasBase + `BIAS_ADDR_WIDTH'(curK);
        weightCol      <= curKx;
    end

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            active    <= 1'b0;
            issueDone <= 1'b0;
            issueTag  <= '0;
            kCnt      <= '0;
            oyCnt     <= '0;
            oxCnt     <= '0;
            dCnt      <= '0;
            kyCnt     <= '0;
            kxCnt     <= '0;
        end else begin
            issueTag <= '{valid: issuing, first: firstElem, last: wrapD};
            if (issuing) begin
                kCnt      <= nK;
                oyCnt     <= nOy;
                oxCnt     <= nOx;
                dCnt      <= nD;
                kyCnt     <= nKy;
                kxCnt     <= nKx;
                active    <= !allDone;
                issueDone <= allDone;   // held until the next start
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/macLine.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module macLine (
    input  wire                                        clk,
    input  wire                                        convRst,
    input  wire convPkg::macTag_t                      issueTag,
    input  wire [`KIDX_WIDTH-1:0]                      weightCol,
    input  wire signed [`DATA_WIDTH-1:0]               readFM,
    input  wire [`KERNEL-1:0][`DATA_WIDTH-1:0]         readWeight,   // column 0 in low bits
    input  wire signed [`DATA_WIDTH-1:0]               readBias,
    output convPkg::macResult_t                        macOut
);

    convPkg::macTag_t                tagD1, tagD2;
    logic [`KIDX_WIDTH-1:0]          colD1;
    logic signed [2*`DATA_WIDTH-1:0] product;
    logic signed [`ACC_WIDTH-1:0]    prodExt;
    logic signed [`ACC_WIDTH-1:0]    acc;
    logic signed [`ACC_WIDTH-1:0]    sumNext;
    logic signed [`DATA_WIDTH-1:0]   biasHold;

    // tag meets the returned RAM words here
    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            tagD1 <= '0;
            tagD2 <= '0;
        end else begin
            tagD1 <= issueTag;
            tagD2 <= tagD1;
        end
    end

    always_ff @(posedge clk) begin
        colD1   <= weightCol;
        product <= (2*`DATA_WIDTH)'(readFM)
                 * (2*`DATA_WIDTH)'($signed(readWeight[colD1]));
        if (tagD1.valid && tagD1.first) begin
            biasHold <= readBias;   // one bias per pixel
        end
    end

    assign prodExt = `ACC_WIDTH'(product);
    assign sumNext = tagD2.first ? prodExt : acc + prodExt;

    always_ff @(posedge clk) begin
        if (tagD2.valid) begin
            acc <= sumNext;
        end
    end

    // emitted with the last element, next pixel may already be in flight
    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            macOut <= '0;
        end else begin
            macOut <= '{valid: tagD2.valid & tagD2.last, sum: sumNext, bias: biasHold};
        end
    end

endmodule

`default_nettype wire

//--- verilog/resultWriter.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module resultWriter (
    input  wire                       clk,
    input  wire                       convRst,
    input  wire convPkg::layerCfg_t   cfg,
    input  wire                       start,
    input  wire                       issueDone,
    input  wire convPkg::macResult_t  macOut,
    output convPkg::layerWrite_t      writeLayer,
    output logic                      convStatus
);

    logic signed [`ACC_WIDTH-1:0]  shifted;
    logic signed [`ACC_WIDTH-1:0]  biased;
    logic [`DATA_WIDTH-1:0]        satVal;
    logic [`DATA_WIDTH-1:0]        reluVal;
    logic [`LAYER_ADDR_WIDTH-1:0]  wrCount;
    logic [`LAYER_ADDR_WIDTH-1:0]  total;

    // truncating round, back to Q8.8
    assign shifted = $signed(macOut.sum) >>> `FRAC_BITS;
    assign biased  = shifted + `ACC_WIDTH'($signed(macOut.bias));

    always_comb begin
        if (!biased[`ACC_WIDTH-1] && |biased[`ACC_WIDTH-2:`DATA_WIDTH-1]) begin
            satVal = {1'b0, {(`DATA_WIDTH-1){1'b1}}};           // 32767
        end else if (biased[`ACC_WIDTH-1] && !(&biased[`ACC_WIDTH-2:`DATA_WIDTH-1])) begin
            satVal = {1'b1, {(`DATA_WIDTH-1){1'b0}}};           // -32768
        end else begin
            satVal = biased[`DATA_WIDTH-1:0];
        end
    end

    assign reluVal = satVal[`DATA_WIDTH-1] ? '0 : satVal;  // relu

    assign total = `LAYER_ADDR_WIDTH'(cfg.kernels) * `LAYER_ADDR_WIDTH'(cfg.outSize)
                 * `LAYER_ADDR_WIDTH'(cfg.outSize);

    // pixels arrive in kernel, row, column order so the offset is the count
    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            writeLayer <= '0;
            wrCount    <= '0;
            convStatus <= 1'b0;
        end else begin
            writeLayer.en <= macOut.valid;
            if (macOut.valid) begin
                writeLayer.addr <= cfg.outBase + wrCount;
                writeLayer.data <= reluVal;
            end
            if (start) begin
                wrCount    <= '0;
                convStatus <= 1'b0;
            end else begin
                if (macOut.valid) begin
                    wrCount <= wrCount + 1'b1;
                end
                if (issueDone && wrCount == total) begin
                    convStatus <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/convEngine.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module convEngine (
    input  wire                              clk,
    input  wire                              convRst,
    input  wire [`LAYER_CODE_WIDTH-1:0]      runLayer,
    input  wire [`DATA_WIDTH-1:0]            readFM,
    input  wire [`KERNEL*`DATA_WIDTH-1:0]    readWeight,   // one kernel row
    input  wire [`DATA_WIDTH-1:0]            readBias,
    output logic [`LAYER_ADDR_WIDTH-1:0]     layerReadAddr,
    output logic [`WEIGHT_ADDR_WIDTH-1:0]    weightReadAddr,
    output logic [`BIAS_ADDR_WIDTH-1:0]      biasReadAddr,
    output convPkg::layerWrite_t             writeLayer,
    output logic                             convStatus
);

    convPkg::layerCfg_t     cfg;
    logic                   start;
    convPkg::macTag_t       issueTag;
    logic [`KIDX_WIDTH-1:0] weightCol;
    logic                   issueDone;
    convPkg::macResult_t    macOut;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    layerDecode u_layerDecode (
        .clk      (clk),
        .convRst  (convRst),
        .runLayer (runLayer),
        .cfg      (cfg),
        .start    (start)
    );

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////

    convWindowCtrl u_convWindowCtrl (
        .clk            (clk),
        .convRst        (convRst),
        .cfg            (cfg),
        .start          (start),
        .layerReadAddr  (layerReadAddr),
        .weightReadAddr (weightReadAddr),
        .biasReadAddr   (biasReadAddr),
        .issueTag       (issueTag),
        .weightCol      (weightCol),
        .issueDone      (issueDone)
    );

    macLine u_macLine (
        .clk        (clk),
        .convRst    (convRst),
        .issueTag   (issueTag),
        .weightCol  (weightCol),
        .readFM     (readFM),
        .readWeight (readWeight),
        .readBias   (readBias),
        .macOut     (macOut)
    );

    //////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////

    resultWriter u_resultWriter (
        .clk        (clk),
        .convRst    (convRst),
        .cfg        (cfg),
        .start      (start),
        .issueDone  (issueDone),
        .macOut     (macOut),
        .writeLayer (writeLayer),
        .convStatus (convStatus)
    );

endmodule

`default_nettype wire

//--- sim/convEngine_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module convEngine_tb;

    localparam int CLK_PERIOD = 20;
    localparam int OUT1 = (`CONV1_FM - `KERNEL) / `CONV1_STRIDE + 1;
    localparam int OUT2 = (`CONV2_FM - `KERNEL) / `CONV2_STRIDE + 1;
    localparam int PIX_CYCLES1 = `KERNEL * `KERNEL * `CONV1_FM_DEPTH;
    localparam int PIX_CYCLES2 = `KERNEL * `KERNEL * `CONV2_FM_DEPTH;
    localparam int CONV1_CYCLES = `CONV1_KERNELS * OUT1 * OUT1 * PIX_CYCLES1;
    localparam int CONV2_CYCLES = `CONV2_KERNELS * OUT2 * OUT2 * PIX_CYCLES2;
    localparam int WATCHDOG_CYCLES = 2 * CONV1_CYCLES + CONV2_CYCLES + 400;  // conv1 runs twice

    logic                                clk;
    logic                                convRst;
    logic [`LAYER_CODE_WIDTH-1:0]        runLayer;
    logic [`DATA_WIDTH-1:0]              readFM;
    logic [`KERNEL*`DATA_WIDTH-1:0]      readWeight;
    logic [`DATA_WIDTH-1:0]              readBias;
    logic [`LAYER_ADDR_WIDTH-1:0]        layerReadAddr, fmAddrQ;
    logic [`WEIGHT_ADDR_WIDTH-1:0]       weightReadAddr, wAddrQ;
    logic [`BIAS_ADDR_WIDTH-1:0]         biasReadAddr, bAddrQ;
    convPkg::layerWrite_t                writeLayer;
    logic                                convStatus;

    logic signed [`DATA_WIDTH-1:0] layerMem [0:(1<<`LAYER_ADDR_WIDTH)-1];
    logic signed [`DATA_WIDTH-1:0] weightMem [0:(1<<`WEIGHT_ADDR_WIDTH)-1][0:`KERNEL-1];
    logic signed [`DATA_WIDTH-1:0] biasMem [0:(1<<`BIAS_ADDR_WIDTH)-1];

    int expIn, expOut, expFm, expDepth, expKernels, expStride;
    int expOutSize, expTotal, expWb, expBb;
    int wrIdx, errors, checks;
    bit expectWrites, sawMax, sawZero;
    int rngState = 22566;

    convEngine uut (
        .clk            (clk),
        .convRst        (convRst),
        .runLayer       (runLayer),
        .readFM         (readFM),
        .readWeight     (readWeight),
        .readBias       (readBias),
        .layerReadAddr  (layerReadAddr),
        .weightReadAddr (weightReadAddr),
        .biasReadAddr   (biasReadAddr),
        .writeLayer     (writeLayer),
        .convStatus     (convStatus)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // RAM models, one-cycle read
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        fmAddrQ = layerReadAddr;    // address registered at the previous edge
        wAddrQ  = weightReadAddr;
        bAddrQ  = biasReadAddr;
        #2;
        readFM     = layerMem[fmAddrQ];
        readWeight = {weightMem[wAddrQ][2], weightMem[wAddrQ][1], weightMem[wAddrQ][0]};
        readBias   = biasMem[bAddrQ];
    end

    function automatic logic signed [`DATA_WIDTH-1:0] nextRandom(input int span);
        rngState = rngState * 1103515245 + 12345;
        return `DATA_WIDTH'(int'(rngState[30:16]) % (2 * span + 1) - span);
    endfunction

    // expected output pixel, Q8.8 with truncation, saturation and relu
    function automatic logic [`DATA_WIDTH-1:0] convRef(input int k, input int oy, input int ox);
        longint acc;
        longint val;
        int inAddr;
        int wRow;
        acc = 0;
        for (int d = 0; d < expDepth; d++) begin
            for (int ky = 0; ky < `KERNEL; ky++) begin
                for (int kx = 0; kx < `KERNEL; kx++) begin
                    inAddr = expIn + d * expFm * expFm + (oy * expStride + ky) * expFm
                           + ox * expStride + kx;
                    wRow   = expWb + k * expDepth * `KERNEL + d * `KERNEL + ky;
                    acc    = acc + longint'(layerMem[inAddr]) * longint'(weightMem[wRow][kx]);
                end
            end
        end
        val = (acc >>> `FRAC_BITS) + longint'(biasMem[expBb + k]);
        if (val > 32767) val = 32767;
        if (val < 0) val = 0;
        return `DATA_WIDTH'(val);
    endfunction

    task automatic reportValue(input string name, input int got, input int want);
        errors++;
        $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, want);
    endtask

    task automatic setExpected(input int code);
        expIn      = (code == `LAYER_CONV1) ? `LAYER_RAM_START_INDEX_0 : `LAYER_RAM_START_INDEX_1;
        expOut     = (code == `LAYER_CONV1) ? `LAYER_RAM_START_INDEX_1 : `LAYER_RAM_START_INDEX_0;
        expFm      = (code == `LAYER_CONV1) ? `CONV1_FM : `CONV2_FM;
        expDepth   = (code == `LAYER_CONV1) ? `CONV1_FM_DEPTH : `CONV2_FM_DEPTH;
        expKernels = (code == `LAYER_CONV1) ? `CONV1_KERNELS : `CONV2_KERNELS;
        expStride  = (code == `LAYER_CONV1) ? `CONV1_STRIDE : `CONV2_STRIDE;
        expWb      = (code == `LAYER_CONV1) ? `CONV1_WEIGHT_BASE : `CONV2_WEIGHT_BASE;
        expBb      = (code == `LAYER_CONV1) ? `CONV1_BIAS_BASE : `CONV2_BIAS_BASE;
        expOutSize = (expFm - `KERNEL) / expStride + 1;
        expTotal   = expKernels * expOutSize * expOutSize;
        wrIdx      = 0;
        expectWrites = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // write checker
    //////////////////////////////////////////////////

    task automatic checkWrite();
        int plane;
        int pix;
        int expAddr;
        logic [`DATA_WIDTH-1:0] expData;
        checks++;
        assert (expectWrites && wrIdx < expTotal) else begin
            errors++;
            $display("Unexpected layer write to address %0d at %0t", writeLayer.addr, $time);
        end
        if (expectWrites && wrIdx < expTotal) begin
            plane   = expOutSize * expOutSize;
            pix     = wrIdx % plane;
            expAddr = expOut + (wrIdx / plane) * plane + (pix / expOutSize) * expOutSize
                    + pix % expOutSize;
            expData = convRef(wrIdx / plane, pix / expOutSize, pix % expOutSize);
            checks  = checks + 3;
            assert (int'(writeLayer.addr) == expAddr)
                else reportValue("writeLayer.addr", writeLayer.addr, expAddr);
            assert (writeLayer.data == expData)
                else reportValue("writeLayer.data", writeLayer.data, expData);
            assert (!convStatus) else reportValue("convStatus", convStatus, 0);
            if (writeLayer.data == 16'h7fff) sawMax = 1'b1;
            if (writeLayer.data == '0) sawZero = 1'b1;
            wrIdx++;
        end
        layerMem[writeLayer.addr] = writeLayer.data;
    endtask

    always @(negedge clk) begin
        if (writeLayer.en) begin
            checkWrite();
        end
    end

    task automatic driveLayer(input int code);
        @(posedge clk);
        #2 runLayer = `LAYER_CODE_WIDTH'(code);
    endtask

    task automatic holdQuiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checks++;
            assert (!convStatus) else reportValue("convStatus", convStatus, 0);
        end
    endtask

    task automatic runConv(input int code);
        setExpected(code);
        driveLayer(code);
        while (convStatus) @(negedge clk);     // cleared by the new start
        while (!convStatus) @(negedge clk);
        checks++;
        assert (wrIdx == expTotal) else reportValue("write count", wrIdx, expTotal);
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (convStatus) else reportValue("convStatus", convStatus, 1);
        end
        expectWrites = 1'b0;
    endtask

    // kernel 0 large positive, kernel 1 large negative
    task automatic forceSaturation();
        for (int a = 0; a < `CONV1_FM * `CONV1_FM * `CONV1_FM_DEPTH; a++) begin
            layerMem[`LAYER_RAM_START_INDEX_0 + a] = 16'sh0100 + `DATA_WIDTH'(a);
        end
        for (int r = 0; r < `CONV1_KERNELS * `CONV1_FM_DEPTH * `KERNEL; r++) begin
            for (int c = 0; c < `KERNEL; c++) begin
                weightMem[`CONV1_WEIGHT_BASE + r][c] =
                    (r < `CONV1_FM_DEPTH * `KERNEL) ? 16'sh7000 : -16'sh7000;
            end
        end
    endtask

    initial begin
        convRst = 1'b1;
        runLayer = `LAYER_CODE_WIDTH'(`LAYER_IDLE);
        readFM = '0;
        readWeight = '0;
        readBias = '0;
        errors = 0;
        checks = 0;
        expectWrites = 1'b0;
        for (int a = 0; a < (1 << `LAYER_ADDR_WIDTH); a++) layerMem[a] = nextRandom(256);
        for (int a = 0; a < (1 << `WEIGHT_ADDR_WIDTH); a++) begin
            for (int c = 0; c < `KERNEL; c++) weightMem[a][c] = nextRandom(128);
        end
        for (int a = 0; a < (1 << `BIAS_ADDR_WIDTH); a++) biasMem[a] = nextRandom(512);
        repeat (8) @(posedge clk);
        #2 convRst = 1'b0;
        holdQuiet(30);                  // idle after reset
        driveLayer(2);                  // pool1 is not supported
        holdQuiet(40);
        runConv(`LAYER_CONV1);
        runConv(`LAYER_CONV2);          // chained from region 1
        driveLayer(`LAYER_IDLE);
        repeat (5) @(posedge clk);
        forceSaturation();
        sawMax = 1'b0;
        sawZero = 1'b0;
        runConv(`LAYER_CONV1);
        checks++;
        assert (sawMax && sawZero) else begin
            errors++;
            $display("Forced case did not produce both a saturated and a zero output");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: layer runs did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/convPkg.sv
verilog/layerDecode.sv
verilog/convWindowCtrl.sv
verilog/macLine.sv
verilog/resultWriter.sv
verilog/convEngine.sv
sim/convEngine_tb.sv

//--- Makefile
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= convEngine_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/conv_macros.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
